/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// peripheral strobe bus
	localparam int DATA_W = 32;
	localparam int ADDR_W = 6;
	localparam int SEL_W  = 4;

	// one character
	localparam int BYTE_W = 8;

	// word addresses inside the UART window, bits 7:2 of the device address
	typedef enum logic [ADDR_W-1:0] {
		REG_DATA   = 6'd0,
		REG_STATUS = 6'd1,
		REG_CTRL   = 6'd2
	} reg_addr_e;

	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_e;

	// status word layout
	localparam int ST_EMPTY     = 0;
	localparam int ST_FULL      = 1;
	localparam int ST_BUSY      = 2;
	localparam int ST_OVERFLOW  = 3;
	localparam int ST_ENABLE    = 4;
	// fill count, up to 8 bits
	localparam int ST_COUNT_LSB = 16;

	// control register
	localparam int CTRL_ENABLE  = 0;

endpackage

`default_nettype wire

/* uart_bus_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_bus_regs #(
	parameter int FIFO_ADDR_WIDTH = 3,
	parameter int TX_IR_THRESHOLD = 4
) (
	input  logic                         clk_cpu,
	input  logic                         arst_n_i,
	input  logic                         cs_i,
	input  logic [uart_pkg::ADDR_W-1:0]  addr_i,
	input  logic [uart_pkg::SEL_W-1:0]   sel_i,
	input  logic                         we_i,
	input  logic [uart_pkg::DATA_W-1:0]  data_i,
	output logic [uart_pkg::DATA_W-1:0]  data_o,
	output logic                         ack_o,
	output logic                         ir_o,
	output logic                         push_o,
	output logic [uart_pkg::BYTE_W-1:0]  push_data_o,
	input  logic                         fifo_full_i,
	input  logic                         fifo_empty_i,
	input  logic [FIFO_ADDR_WIDTH:0]     fifo_count_i,
	input  logic                         tx_busy_i,
	output logic                         tx_enable_o
);

	localparam logic [FIFO_ADDR_WIDTH:0] IR_LEVEL = (FIFO_ADDR_WIDTH+1)'(TX_IR_THRESHOLD);

	logic                        ack_q;
	logic [uart_pkg::DATA_W-1:0] rd_data_q;
	logic [uart_pkg::DATA_W-1:0] rd_mux;
	logic [uart_pkg::DATA_W-1:0] status_word;
	logic                        overflow_q;
	logic                        tx_enable_q;
	logic                        wr_data;
	logic                        wr_status;
	logic                        wr_ctrl;

	// write decode, only lane 0 matters for data and ctrl
	always_comb begin
		wr_data   = 1'b0;
		wr_status = 1'b0;
		wr_ctrl   = 1'b0;
		if (cs_i && we_i) begin
			case (uart_pkg::reg_addr_e'(addr_i))
				uart_pkg::REG_DATA:   wr_data   = sel_i[0];
				uart_pkg::REG_STATUS: wr_status = 1'b1;
				uart_pkg::REG_CTRL:   wr_ctrl   = sel_i[0];
				default: ;
			endcase
		end
	end

	// full FIFO drops the character
	assign push_o      = wr_data & ~fifo_full_i;
	assign push_data_o = data_i[uart_pkg::BYTE_W-1:0];

	always_comb begin
		status_word = '0;
		status_word[uart_pkg::ST_EMPTY]    = fifo_empty_i;
		status_word[uart_pkg::ST_FULL]     = fifo_full_i;
		status_word[uart_pkg::ST_BUSY]     = tx_busy_i;
		status_word[uart_pkg::ST_OVERFLOW] = overflow_q;
		status_word[uart_pkg::ST_ENABLE]   = tx_enable_q;
		status_word[uart_pkg::ST_COUNT_LSB +: FIFO_ADDR_WIDTH+1] = fifo_count_i;
	end

	always_comb begin
		rd_mux = '0;
		case (uart_pkg::reg_addr_e'(addr_i))
			uart_pkg::REG_STATUS: rd_mux = status_word;
			uart_pkg::REG_CTRL:   rd_mux[uart_pkg::CTRL_ENABLE] = tx_enable_q;
			default: ;
		endcase
	end

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q       <= 1'b0;
			rd_data_q   <= '0;
			overflow_q  <= 1'b0;
			tx_enable_q <= 1'b0;
		end else begin
			ack_q <= cs_i;
			// read data only lives in the ack cycle
			rd_data_q <= (cs_i && !we_i) ? rd_mux : '0;
			if (wr_data && fifo_full_i) begin
				overflow_q <= 1'b1;
			end else if (wr_status) begin
				overflow_q <= 1'b0;
			end
			if (wr_ctrl) begin
				tx_enable_q <= data_i[uart_pkg::CTRL_ENABLE];
			end
		end
	end

	assign ack_o       = ack_q;
	assign data_o      = rd_data_q;
	assign tx_enable_o = tx_enable_q;

	// level interrupt on low fill
	assign ir_o = (fifo_count_i < IR_LEVEL);

	a_ack_single: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		ack_o |=> !ack_o)
		else $error("ack_o held for two cycles");

endmodule

`default_nettype wire

/* uart_tx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo #(
	parameter int FIFO_ADDR_WIDTH = 3
) (
	input  logic                        clk_cpu,
	input  logic                        arst_n_i,
	input  logic                        push_i,
	input  logic [uart_pkg::BYTE_W-1:0] push_data_i,
	input  logic                        pop_i,
	output logic [uart_pkg::BYTE_W-1:0] head_data_o,
	output logic                        full_o,
	output logic                        empty_o,
	output logic [FIFO_ADDR_WIDTH:0]    count_o
);

	localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

	logic [uart_pkg::BYTE_W-1:0] mem [DEPTH];
	logic [FIFO_ADDR_WIDTH-1:0]  wr_ptr_q;
	logic [FIFO_ADDR_WIDTH-1:0]  rd_ptr_q;
	logic [FIFO_ADDR_WIDTH:0]    count_q;

	// storage
	always_ff @(posedge clk_cpu) begin
		if (push_i) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// first word falls through
	assign head_data_o = mem[rd_ptr_q];

	assign count_o = count_q;
	assign full_o  = (count_q == (FIFO_ADDR_WIDTH+1)'(DEPTH));
	assign empty_o = (count_q == '0);

	a_no_push_full: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		push_i |-> !full_o)
		else $error("push into full FIFO");

	a_no_pop_empty: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		pop_i |-> !empty_o)
		else $error("pop from empty FIFO");

endmodule

`default_nettype wire

/* uart_tx_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer #(
	parameter int CYCLES_PER_BIT = 10
) (
	input  logic                        clk_cpu,
	input  logic                        arst_n_i,
	input  logic                        enable_i,
	input  logic                        empty_i,
	input  logic [uart_pkg::BYTE_W-1:0] head_data_i,
	output logic                        pop_o,
	output logic                        busy_o,
	output logic                        tx_o
);

	localparam int CNT_W = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES_PER_BIT - 1);

	uart_pkg::tx_state_e         state_q;
	logic [CNT_W-1:0]            baud_cnt_q;
	logic [2:0]                  bit_idx_q;
	logic [uart_pkg::BYTE_W-1:0] shift_q;
	logic                        tx_q;
	logic                        bit_end;

	assign bit_end = (baud_cnt_q == CNT_LAST);

	// take the next character only from idle
	assign pop_o  = (state_q == uart_pkg::TX_IDLE) & enable_i & ~empty_i;
	assign busy_o = (state_q != uart_pkg::TX_IDLE);
	assign tx_o   = tx_q;

	// character shift register, LSB goes out first
	always_ff @(posedge clk_cpu) begin
		if (pop_o) begin
			shift_q <= head_data_i;
		end else if (state_q == uart_pkg::TX_DATA && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= uart_pkg::TX_IDLE;
			baud_cnt_q <= '0;
			bit_idx_q  <= '0;
			tx_q       <= 1'b1;
		end else begin
			if (state_q == uart_pkg::TX_IDLE || bit_end) begin
				baud_cnt_q <= '0;
			end else begin
				baud_cnt_q <= baud_cnt_q + 1'b1;
			end

			case (state_q)
				uart_pkg::TX_IDLE: begin
					tx_q <= 1'b1;
					if (pop_o) begin
						state_q <= uart_pkg::TX_START;
						tx_q    <= 1'b0;
					end
				end
				uart_pkg::TX_START: begin
					if (bit_end) begin
						state_q   <= uart_pkg::TX_DATA;
						bit_idx_q <= '0;
						tx_q      <= shift_q[0];
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx_q == 3'd7) begin
							state_q <= uart_pkg::TX_STOP;
							tx_q    <= 1'b1;
						end else begin
							bit_idx_q <= bit_idx_q + 1'b1;
							tx_q      <= shift_q[1];
						end
					end
				end
				uart_pkg::TX_STOP: begin
					// next pop happens one cycle later from idle
					if (bit_end) begin
						state_q <= uart_pkg::TX_IDLE;
					end
				end
				default: begin
					state_q <= uart_pkg::TX_IDLE;
					tx_q    <= 1'b1;
				end
			endcase
		end
	end

	a_idle_line_high: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		(state_q == uart_pkg::TX_IDLE) |-> tx_o)
		else $error("tx_o low while serializer idle");

endmodule

`default_nettype wire

/* uart_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_top #(
	parameter int FIFO_ADDR_WIDTH = 3,
	parameter int CYCLES_PER_BIT  = 10,
	parameter int TX_IR_THRESHOLD = 4
) (
	input  logic                        clk_cpu,
	input  logic                        arst_n_i,
	input  logic                        cs_i,
	input  logic [uart_pkg::ADDR_W-1:0] addr_i,
	input  logic [uart_pkg::SEL_W-1:0]  sel_i,
	input  logic                        we_i,
	input  logic [uart_pkg::DATA_W-1:0] data_i,
	output logic [uart_pkg::DATA_W-1:0] data_o,
	output logic                        ack_o,
	output logic                        tx_o,
	output logic                        ir_o
);

	logic                        push;
	logic [uart_pkg::BYTE_W-1:0] push_data;
	logic                        pop;
	logic [uart_pkg::BYTE_W-1:0] head_data;
	logic                        fifo_full;
	logic                        fifo_empty;
	logic [FIFO_ADDR_WIDTH:0]    fifo_count;
	logic                        tx_busy;
	logic                        tx_enable;

	uart_bus_regs #(
		.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH),
		.TX_IR_THRESHOLD(TX_IR_THRESHOLD)
	) u_regs (
		.clk_cpu      (clk_cpu),
		.arst_n_i     (arst_n_i),
		.cs_i         (cs_i),
		.addr_i       (addr_i),
		.sel_i        (sel_i),
		.we_i         (we_i),
		.data_i       (data_i),
		.data_o       (data_o),
		.ack_o        (ack_o),
		.ir_o         (ir_o),
		.push_o       (push),
		.push_data_o  (push_data),
		.fifo_full_i  (fifo_full),
		.fifo_empty_i (fifo_empty),
		.fifo_count_i (fifo_count),
		.tx_busy_i    (tx_busy),
		.tx_enable_o  (tx_enable)
	);

	uart_tx_fifo #(
		.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
	) u_fifo (
		.clk_cpu     (clk_cpu),
		.arst_n_i    (arst_n_i),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (pop),
		.head_data_o (head_data),
		.full_o      (fifo_full),
		.empty_o     (fifo_empty),
		.count_o     (fifo_count)
	);

	uart_tx_serializer #(
		.CYCLES_PER_BIT(CYCLES_PER_BIT)
	) u_ser (
		.clk_cpu     (clk_cpu),
		.arst_n_i    (arst_n_i),
		.enable_i    (tx_enable),
		.empty_i     (fifo_empty),
		.head_data_i (head_data),
		.pop_o       (pop),
		.busy_o      (tx_busy),
		.tx_o        (tx_o)
	);

endmodule

`default_nettype wire

/* tb_uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_tx;

	localparam int FIFO_ADDR_WIDTH = 3;
	localparam int CYCLES_PER_BIT  = 10;
	localparam int TX_IR_THRESHOLD = 4;
	localparam int DEPTH           = 1 << FIFO_ADDR_WIDTH;
	localparam int BURST_LEN       = 20;
	// single frame, one FIFO fill, then the burst
	localparam int TOTAL_BYTES = 1 + DEPTH + BURST_LEN;
	localparam int CYCLE_LIMIT = (TOTAL_BYTES + 4) * 10 * CYCLES_PER_BIT + 2000;

	logic                        clk_cpu;
	logic                        arst_n_i;
	logic                        cs_i;
	logic [uart_pkg::ADDR_W-1:0] addr_i;
	logic [uart_pkg::SEL_W-1:0]  sel_i;
	logic                        we_i;
	logic [uart_pkg::DATA_W-1:0] data_i;
	logic [uart_pkg::DATA_W-1:0] data_o;
	logic                        ack_o;
	logic                        tx_o;
	logic                        ir_o;

	logic [7:0] exp_q[$];
	int         rx_count;
	int         cycle_count;
	bit         model_ovf;
	bit         model_en;

	uart_tx_top #(
		.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH),
		.CYCLES_PER_BIT (CYCLES_PER_BIT),
		.TX_IR_THRESHOLD(TX_IR_THRESHOLD)
	) uut (
		.clk_cpu (clk_cpu),
		.arst_n_i(arst_n_i),
		.cs_i    (cs_i),
		.addr_i  (addr_i),
		.sel_i   (sel_i),
		.we_i    (we_i),
		.data_i  (data_i),
		.data_o  (data_o),
		.ack_o   (ack_o),
		.tx_o    (tx_o),
		.ir_o    (ir_o)
	);

	always #50 clk_cpu = ~clk_cpu;

	always @(posedge clk_cpu) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: the run took more than %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$fatal(1, "cycle limit exceeded");
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, why);
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	// expected status word for an idle line
	function automatic logic [31:0] status_model(input int count, input bit ovf, input bit en);
		logic [31:0] w;
		w = '0;
		w[uart_pkg::ST_EMPTY]    = (count == 0);
		w[uart_pkg::ST_FULL]     = (count == DEPTH);
		w[uart_pkg::ST_OVERFLOW] = ovf;
		w[uart_pkg::ST_ENABLE]   = en;
		w[uart_pkg::ST_COUNT_LSB +: 8] = 8'(count);
		return w;
	endfunction

	// bytes accepted but not yet seen on the line
	function automatic int model_count();
		return exp_q.size() - rx_count;
	endfunction

	task automatic write_reg(input logic [uart_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
		@(posedge clk_cpu);
		#1;
		cs_i   = 1'b1;
		we_i   = 1'b1;
		addr_i = addr;
		sel_i  = 4'hf;
		data_i = data;
		@(posedge clk_cpu);
		#1;
		cs_i = 1'b0;
		we_i = 1'b0;
		if (ack_o !== 1'b1) begin
			abort_run("no acknowledge in the cycle after a write strobe");
		end
	endtask

	task automatic read_reg(input logic [uart_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
		@(posedge clk_cpu);
		#1;
		cs_i   = 1'b1;
		we_i   = 1'b0;
		addr_i = addr;
		sel_i  = 4'hf;
		@(posedge clk_cpu);
		#1;
		cs_i = 1'b0;
		data = data_o;
		if (ack_o !== 1'b1) begin
			abort_run("no acknowledge in the cycle after a read strobe");
		end
	endtask

	// longer than a frame of high line means nothing is in flight
	task automatic wait_line_idle();
		int high_run;
		high_run = 0;
		while (high_run <= 10 * CYCLES_PER_BIT) begin
			@(posedge clk_cpu);
			#1;
			if (tx_o === 1'b1) begin
				high_run++;
			end else begin
				high_run = 0;
			end
		end
	endtask

	// serial line monitor sampling at mid-bit
	initial begin
		logic [7:0] rx_byte;
		@(posedge arst_n_i);
		forever begin
			@(negedge tx_o);
			repeat (CYCLES_PER_BIT / 2) @(negedge clk_cpu);
			if (tx_o !== 1'b0) begin
				abort_run("start bit was not low at mid-bit");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CYCLES_PER_BIT) @(negedge clk_cpu);
				rx_byte[i] = tx_o;
			end
			repeat (CYCLES_PER_BIT) @(negedge clk_cpu);
			if (tx_o !== 1'b1) begin
				abort_run("stop bit was not high at mid-bit");
			end
			if (rx_count >= exp_q.size()) begin
				abort_run("a frame arrived with no byte expected");
			end
			compare_value("rx byte", 32'(exp_q[rx_count]), 32'(rx_byte));
			rx_count++;
		end
	end

	initial begin
		logic [31:0] rd;
		logic [7:0]  b;
		clk_cpu     = 1'b0;
		arst_n_i    = 1'b0;
		cs_i        = 1'b0;
		addr_i      = '0;
		sel_i       = '0;
		we_i        = 1'b0;
		data_i      = '0;
		rx_count    = 0;
		cycle_count = 0;
		model_ovf   = 1'b0;
		model_en    = 1'b0;
		void'($urandom(32'hc3ea_a917));
		repeat (5) @(posedge clk_cpu);
		#1;
		arst_n_i = 1'b1;

		// reset values
		compare_value("reset tx_o", 32'd1, 32'(tx_o));
		compare_value("reset ir_o", 32'd1, 32'(ir_o));
		read_reg(uart_pkg::REG_STATUS, rd);
		compare_value("reset status", status_model(0, 1'b0, 1'b0), rd);
		read_reg(uart_pkg::REG_CTRL, rd);
		compare_value("reset ctrl", 32'd0, rd);
		read_reg(6'h3f, rd);
		compare_value("unknown address read", 32'd0, rd);

		// single frame
		write_reg(uart_pkg::REG_CTRL, 32'd1);
		model_en = 1'b1;
		read_reg(uart_pkg::REG_CTRL, rd);
		compare_value("enabled ctrl", 32'(model_en), rd);
		b = 8'($urandom);
		exp_q.push_back(b);
		write_reg(uart_pkg::REG_DATA, {24'd0, b});
		wait_line_idle();
		compare_value("single frame received", 32'(exp_q.size()), 32'(rx_count));

		// fill with the transmitter off
		write_reg(uart_pkg::REG_CTRL, 32'd0);
		model_en = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			b = 8'($urandom);
			exp_q.push_back(b);
			write_reg(uart_pkg::REG_DATA, {24'd0, b});
			compare_value("fill ir_o", 32'(model_count() < TX_IR_THRESHOLD), 32'(ir_o));
		end
		read_reg(uart_pkg::REG_STATUS, rd);
		compare_value("full status", status_model(model_count(), model_ovf, model_en), rd);
		// ninth byte is dropped
		write_reg(uart_pkg::REG_DATA, 32'($urandom) & 32'hff);
		model_ovf = 1'b1;
		read_reg(uart_pkg::REG_STATUS, rd);
		compare_value("overflow status", status_model(model_count(), model_ovf, model_en), rd);
		write_reg(uart_pkg::REG_CTRL, 32'd1);
		model_en = 1'b1;
		wait_line_idle();
		compare_value("drained bytes", 32'(exp_q.size()), 32'(rx_count));
		// overflow is sticky across the drain
		read_reg(uart_pkg::REG_STATUS, rd);
		compare_value("drained status", status_model(model_count(), model_ovf, model_en), rd);

		// clear overflow
		write_reg(uart_pkg::REG_STATUS, 32'd0);
		model_ovf = 1'b0;
		read_reg(uart_pkg::REG_STATUS, rd);
		compare_value("cleared status", status_model(model_count(), model_ovf, model_en), rd);

		// random burst that never overfills the FIFO
		for (int i = 0; i < BURST_LEN; i++) begin
			while (model_count() >= DEPTH) begin
				@(posedge clk_cpu);
			end
			repeat ($urandom_range(30, 0)) @(posedge clk_cpu);
			b = 8'($urandom);
			exp_q.push_back(b);
			write_reg(uart_pkg::REG_DATA, {24'd0, b});
		end
		wait_line_idle();
		compare_value("burst received", 32'(exp_q.size()), 32'(rx_count));
		compare_value("idle ir_o", 32'd1, 32'(ir_o));
		read_reg(uart_pkg::REG_STATUS, rd);
		compare_value("idle status", status_model(model_count(), model_ovf, model_en), rd);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
uart_pkg.sv
uart_bus_regs.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
uart_tx_top.sv
tb_uart_tx.sv

/* Makefile */
TOP := tb_uart_tx

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f src.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
